// ==== src/sram_adapter_consts.svh ====
// SRAM adapter constants
// Bus and SRAM widths, FIFO depth, blanking data and FIFO record widths
`ifndef SRAM_ADAPTER_CONSTS_SVH
`define SRAM_ADAPTER_CONSTS_SVH

// Host bus widths
`define TL_DW 32
`define TL_AW 32
`define TL_SRCW 8
`define TL_SZW 2

// SRAM side, one word holds two bus words
`define SRAM_DW 64
`define SRAM_AW 10

// Entries per FIFO, i.e. requests in flight
`define OUTSTANDING 2

// Returned on errors and on write acks
`define ERR_BLANK_DATA 32'hFFFF_FFFF

// Packed FIFO records: {kind, error, size, source}, {lane, mask}, {data, uerr}
`define REQ_REC_W (1 + 1 + `TL_SZW + `TL_SRCW)
`define LANE_REC_W ($clog2(`SRAM_DW / `TL_DW) + `TL_DW / 8)
`define RSP_REC_W (`TL_DW + 1)

`endif

// ==== src/tl_pkg.sv ====
// Host bus types
// Opcodes of the A and D channels and the widths of the bus fields
`default_nettype none

`include "sram_adapter_consts.svh"

package tl_pkg;

  // A-channel requests that the adapter knows
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } a_opcode_e;

  // D-channel acks, data only on reads
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } d_opcode_e;

  typedef logic [`TL_AW-1:0]   tl_addr_t;
  typedef logic [`TL_DW-1:0]   tl_data_t;
  // One bit per byte lane
  typedef logic [`TL_DW/8-1:0] tl_mask_t;
  // log2 of the byte count
  typedef logic [`TL_SZW-1:0]  tl_size_t;
  typedef logic [`TL_SRCW-1:0] tl_source_t;

endpackage

`default_nettype wire

// ==== src/sram_pkg.sv ====
// SRAM side types
// Word index, wide word, lane offset and the internal request kind
`default_nettype none

`include "sram_adapter_consts.svh"

package sram_pkg;

  // Word index into the SRAM
  typedef logic [`SRAM_AW-1:0] sram_addr_t;

  // Wide data word, also used as bit write mask
  typedef logic [`SRAM_DW-1:0] sram_word_t;

  // Which bus word inside the SRAM word
  typedef logic [$clog2(`SRAM_DW / `TL_DW)-1:0] lane_t;

  // Unknown opcodes travel as reads
  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } req_kind_e;

endpackage

`default_nettype wire

// ==== src/req_checker.sv ====
// A-channel request checker
// Flags bad opcode, size, alignment and mask of the current request
`timescale 1ns/1ps
`default_nettype none

`include "sram_adapter_consts.svh"

module req_checker (
  input  logic                a_valid_i,
  input  tl_pkg::a_opcode_e   a_opcode_i,
  input  tl_pkg::tl_size_t    a_size_i,
  input  tl_pkg::tl_mask_t    a_mask_i,
  input  tl_pkg::tl_addr_t    a_address_i,
  output logic                err_o
);

  // Full bus word
  localparam tl_pkg::tl_size_t MAX_SIZE = tl_pkg::tl_size_t'($clog2(`TL_DW / 8));

  logic             op_err, size_err, align_err, mask_err, full_err;
  tl_pkg::tl_mask_t lane_mask;

  // Byte lanes covered by size and address
  always_comb begin
    align_err = 1'b0;
    case (a_size_i)
      2'd0: lane_mask = tl_pkg::tl_mask_t'(1) << a_address_i[1:0];
      2'd1: begin
        lane_mask = tl_pkg::tl_mask_t'(2'b11) << {a_address_i[1], 1'b0};
        align_err = a_address_i[0];
      end
      default: begin
        lane_mask = '1;
        align_err = |a_address_i[1:0];
      end
    endcase
  end

  assign op_err   = !(a_opcode_i inside {tl_pkg::Get, tl_pkg::PutFullData,
                                         tl_pkg::PutPartialData});
  assign size_err = a_size_i > MAX_SIZE;
  // No byte enable outside the addressed lanes
  assign mask_err = |(a_mask_i & ~lane_mask);
  // Full put must cover every addressed lane
  assign full_err = (a_opcode_i == tl_pkg::PutFullData) && (a_mask_i != lane_mask);

  assign err_o = a_valid_i & (op_err | size_err | align_err | mask_err | full_err);

endmodule

`default_nettype wire

// ==== src/sram_lane_map.sv ====
// Lane mapping between the 32-bit bus and the 64-bit SRAM word
// Places write data and mask in a lane, picks and masks read data
`timescale 1ns/1ps
`default_nettype none

`include "sram_adapter_consts.svh"

module sram_lane_map (
  // Request side
  input  tl_pkg::tl_addr_t    a_address_i,
  input  tl_pkg::tl_mask_t    a_mask_i,
  input  tl_pkg::tl_data_t    a_data_i,
  input  logic                we_i,
  output sram_pkg::sram_addr_t addr_o,
  output sram_pkg::lane_t     lane_o,
  output sram_pkg::sram_word_t wdata_o,
  output sram_pkg::sram_word_t wmask_o,
  // Read return side
  input  sram_pkg::lane_t     rd_lane_i,
  input  tl_pkg::tl_mask_t    rd_mask_i,
  input  sram_pkg::sram_word_t rdata_i,
  output tl_pkg::tl_data_t    rd_data_o
);

  localparam int BYTES  = `TL_DW / 8;
  localparam int LANES  = `SRAM_DW / `TL_DW;
  // Byte offset bits, then lane bits, then word index
  localparam int OFF_W  = $clog2(BYTES);
  localparam int LANE_W = $bits(sram_pkg::lane_t);

  logic [LANES-1:0][`TL_DW-1:0] wmask_lanes;
  logic [LANES-1:0][`TL_DW-1:0] wdata_lanes;
  logic [LANES-1:0][`TL_DW-1:0] rdata_lanes;
  tl_pkg::tl_data_t             rd_bitmask;

  assign addr_o = a_address_i[OFF_W+LANE_W +: `SRAM_AW];
  assign lane_o = a_address_i[OFF_W +: LANE_W];

  // Other lanes stay masked off
  always_comb begin
    wmask_lanes = '0;
    wdata_lanes = '0;
    for (int i = 0; i < BYTES; i++) begin
      wmask_lanes[lane_o][8*i +: 8] = {8{a_mask_i[i]}};
      // Data only on enabled bytes of a write
      wdata_lanes[lane_o][8*i +: 8] = (we_i && a_mask_i[i]) ? a_data_i[8*i +: 8] : 8'h00;
    end
  end

  assign wmask_o = wmask_lanes;
  assign wdata_o = wdata_lanes;

  // Byte mask of the original read request
  always_comb begin
    for (int i = 0; i < BYTES; i++) begin
      rd_bitmask[8*i +: 8] = {8{rd_mask_i[i]}};
    end
  end

  assign rdata_lanes = rdata_i;
  // Unrequested bytes read as zero
  assign rd_data_o   = rdata_lanes[rd_lane_i] & rd_bitmask;

endmodule

`default_nettype wire

// ==== src/sync_fifo.sv ====
// Synchronous FIFO with pointers and a fill count
// Optional pass mode forwards a write through an empty FIFO
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2,
  parameter bit PASS  = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [WIDTH-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [WIDTH-1:0] rdata_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wptr_q, rptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             empty, full, bypass, push, pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty  = (cnt_q == '0);
  assign full   = (cnt_q == CNT_W'(DEPTH));
  assign bypass = PASS & empty;

  assign wready_o = ~full;
  assign rvalid_o = ~empty | (bypass & wvalid_i);
  assign rdata_o  = bypass ? wdata_i : mem_q[rptr_q];

  // A forwarded and consumed write is never stored
  assign push = wvalid_i & ~full & ~(bypass & rready_i);
  assign pop  = rready_i & ~empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/adapter_ctrl.sv ====
// Adapter control
// Gates ready and SRAM request, drives FIFO push/pop, assembles the D response
`timescale 1ns/1ps
`default_nettype none

`include "sram_adapter_consts.svh"

module adapter_ctrl (
  // A channel and checker
  input  logic                   a_valid_i,
  input  tl_pkg::a_opcode_e      a_opcode_i,
  input  tl_pkg::tl_size_t       a_size_i,
  input  tl_pkg::tl_mask_t       a_mask_i,
  input  tl_pkg::tl_source_t     a_source_i,
  input  sram_pkg::lane_t        lane_i,
  input  logic                   err_i,
  output logic                   a_ready_o,
  // SRAM request
  input  logic                   gnt_i,
  output logic                   req_o,
  output logic                   we_o,
  // Request FIFO
  output logic                   reqfifo_wvalid_o,
  input  logic                   reqfifo_wready_i,
  output logic [`REQ_REC_W-1:0]  reqfifo_wdata_o,
  input  logic                   reqfifo_rvalid_i,
  output logic                   reqfifo_rready_o,
  input  logic [`REQ_REC_W-1:0]  reqfifo_rdata_i,
  // Read-lane FIFO
  output logic                   lanefifo_wvalid_o,
  input  logic                   lanefifo_wready_i,
  output logic [`LANE_REC_W-1:0] lanefifo_wdata_o,
  output logic                   lanefifo_rready_o,
  // Response FIFO
  output logic                   rspfifo_wvalid_o,
  output logic [`RSP_REC_W-1:0]  rspfifo_wdata_o,
  input  logic                   rspfifo_rvalid_i,
  output logic                   rspfifo_rready_o,
  input  logic [`RSP_REC_W-1:0]  rspfifo_rdata_i,
  // SRAM read return, uncorrectable bit only
  input  logic                   rvalid_i,
  input  logic                   rerror_i,
  input  tl_pkg::tl_data_t       rd_data_i,
  // D channel
  input  logic                   d_ready_i,
  output logic                   d_valid_o,
  output tl_pkg::d_opcode_e      d_opcode_o,
  output tl_pkg::tl_size_t       d_size_o,
  output tl_pkg::tl_source_t     d_source_o,
  output tl_pkg::tl_data_t       d_data_o,
  output logic                   d_error_o
);

  sram_pkg::req_kind_e kind, head_kind;
  logic                head_err, head_rd_ok, rsp_uerr, d_ack;
  tl_pkg::tl_size_t    head_size;
  tl_pkg::tl_source_t  head_source;
  tl_pkg::tl_data_t    rsp_data;

  // Only puts write, anything else answers with data
  assign we_o = a_valid_i & (a_opcode_i inside {tl_pkg::PutFullData, tl_pkg::PutPartialData});
  assign kind = we_o ? sram_pkg::OpWrite : sram_pkg::OpRead;

  // Errors never reach the SRAM but still need a grant-free accept
  assign req_o     = a_valid_i & reqfifo_wready_i & ~err_i;
  assign a_ready_o = (gnt_i | err_i) & reqfifo_wready_i & lanefifo_wready_i;

  // Every accepted request is remembered for ordering
  assign reqfifo_wvalid_o = a_valid_i & a_ready_o;
  assign reqfifo_wdata_o  = {kind, err_i, a_size_i, a_source_i};

  // Lane and mask wait for the granted read's data
  assign lanefifo_wvalid_o = req_o & gnt_i & ~we_o;
  assign lanefifo_wdata_o  = {lane_i, a_mask_i};

  // No back-pressure toward the SRAM, store every return
  assign rspfifo_wvalid_o  = rvalid_i;
  assign rspfifo_wdata_o   = {rd_data_i, rerror_i};
  assign lanefifo_rready_o = rvalid_i;

  // Head of request FIFO
  assign head_kind   = sram_pkg::req_kind_e'(reqfifo_rdata_i[`REQ_REC_W-1]);
  assign head_err    = reqfifo_rdata_i[`REQ_REC_W-2];
  assign head_size   = reqfifo_rdata_i[`TL_SRCW +: `TL_SZW];
  assign head_source = reqfifo_rdata_i[`TL_SRCW-1:0];

  assign rsp_data = rspfifo_rdata_i[1 +: `TL_DW];
  assign rsp_uerr = rspfifo_rdata_i[0];

  // Read that went to the SRAM
  assign head_rd_ok = (head_kind == sram_pkg::OpRead) & ~head_err;

  // Writes and errors answer at once, reads wait for data
  assign d_valid_o = reqfifo_rvalid_i & (~head_rd_ok | rspfifo_rvalid_i);
  assign d_ack     = d_valid_o & d_ready_i;

  assign reqfifo_rready_o = d_ack;
  assign rspfifo_rready_o = d_ack & head_rd_ok;

  assign d_error_o  = d_valid_o & (head_err | (head_rd_ok & rsp_uerr));
  assign d_data_o   = (d_valid_o & head_rd_ok & ~rsp_uerr) ? rsp_data : `ERR_BLANK_DATA;
  assign d_opcode_o = (head_kind == sram_pkg::OpWrite) ? tl_pkg::AccessAck
                                                       : tl_pkg::AccessAckData;
  assign d_size_o   = d_valid_o ? head_size : '0;
  assign d_source_o = d_valid_o ? head_source : '0;

endmodule

`default_nettype wire

// ==== src/sram_adapter_top.sv ====
// Host bus to wide SRAM adapter
// Checker, lane map, control and request, lane and response FIFOs
`timescale 1ns/1ps
`default_nettype none

`include "sram_adapter_consts.svh"

module sram_adapter_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // A channel
  input  logic                 a_valid_i,
  output logic                 a_ready_o,
  input  tl_pkg::a_opcode_e    a_opcode_i,
  input  tl_pkg::tl_size_t     a_size_i,
  input  tl_pkg::tl_mask_t     a_mask_i,
  input  tl_pkg::tl_addr_t     a_address_i,
  input  tl_pkg::tl_data_t     a_data_i,
  input  tl_pkg::tl_source_t   a_source_i,
  // D channel
  output logic                 d_valid_o,
  input  logic                 d_ready_i,
  output tl_pkg::d_opcode_e    d_opcode_o,
  output tl_pkg::tl_size_t     d_size_o,
  output tl_pkg::tl_source_t   d_source_o,
  output tl_pkg::tl_data_t     d_data_o,
  output logic                 d_error_o,
  // SRAM port
  output logic                 req_o,
  input  logic                 gnt_i,
  output logic                 we_o,
  output sram_pkg::sram_addr_t addr_o,
  output sram_pkg::sram_word_t wdata_o,
  output sram_pkg::sram_word_t wmask_o,
  input  logic                 rvalid_i,
  input  sram_pkg::sram_word_t rdata_i,
  input  logic [1:0]           rerror_i
);

  logic                   err;
  sram_pkg::lane_t        lane;
  tl_pkg::tl_data_t       rd_data;

  logic                   reqfifo_wvalid, reqfifo_wready, reqfifo_rvalid, reqfifo_rready;
  logic [`REQ_REC_W-1:0]  reqfifo_wdata, reqfifo_rdata;
  logic                   lanefifo_wvalid, lanefifo_wready, lanefifo_rready;
  logic [`LANE_REC_W-1:0] lanefifo_wdata, lanefifo_rdata;
  logic                   rspfifo_wvalid, rspfifo_rvalid, rspfifo_rready;
  logic [`RSP_REC_W-1:0]  rspfifo_wdata, rspfifo_rdata;

  req_checker u_checker (
    .a_valid_i  (a_valid_i),
    .a_opcode_i (a_opcode_i),
    .a_size_i   (a_size_i),
    .a_mask_i   (a_mask_i),
    .a_address_i(a_address_i),
    .err_o      (err)
  );

  // Read side takes the lane record at the lane FIFO head
  sram_lane_map u_lane_map (
    .a_address_i(a_address_i),
    .a_mask_i   (a_mask_i),
    .a_data_i   (a_data_i),
    .we_i       (we_o),
    .addr_o     (addr_o),
    .lane_o     (lane),
    .wdata_o    (wdata_o),
    .wmask_o    (wmask_o),
    .rd_lane_i  (lanefifo_rdata[`LANE_REC_W-1 -: $bits(sram_pkg::lane_t)]),
    .rd_mask_i  (lanefifo_rdata[`TL_DW/8-1:0]),
    .rdata_i    (rdata_i),
    .rd_data_o  (rd_data)
  );

  adapter_ctrl u_ctrl (
    .a_valid_i        (a_valid_i),
    .a_opcode_i       (a_opcode_i),
    .a_size_i         (a_size_i),
    .a_mask_i         (a_mask_i),
    .a_source_i       (a_source_i),
    .lane_i           (lane),
    .err_i            (err),
    .a_ready_o        (a_ready_o),
    .gnt_i            (gnt_i),
    .req_o            (req_o),
    .we_o             (we_o),
    .reqfifo_wvalid_o (reqfifo_wvalid),
    .reqfifo_wready_i (reqfifo_wready),
    .reqfifo_wdata_o  (reqfifo_wdata),
    .reqfifo_rvalid_i (reqfifo_rvalid),
    .reqfifo_rready_o (reqfifo_rready),
    .reqfifo_rdata_i  (reqfifo_rdata),
    .lanefifo_wvalid_o(lanefifo_wvalid),
    .lanefifo_wready_i(lanefifo_wready),
    .lanefifo_wdata_o (lanefifo_wdata),
    .lanefifo_rready_o(lanefifo_rready),
    .rspfifo_wvalid_o (rspfifo_wvalid),
    .rspfifo_wdata_o  (rspfifo_wdata),
    .rspfifo_rvalid_i (rspfifo_rvalid),
    .rspfifo_rready_o (rspfifo_rready),
    .rspfifo_rdata_i  (rspfifo_rdata),
    .rvalid_i         (rvalid_i),
    .rerror_i         (rerror_i[1]),
    .rd_data_i        (rd_data),
    .d_ready_i        (d_ready_i),
    .d_valid_o        (d_valid_o),
    .d_opcode_o       (d_opcode_o),
    .d_size_o         (d_size_o),
    .d_source_o       (d_source_o),
    .d_data_o         (d_data_o),
    .d_error_o        (d_error_o)
  );

  // Request order, popped on D ack
  sync_fifo #(.WIDTH(`REQ_REC_W), .DEPTH(`OUTSTANDING), .PASS(1'b0)) u_reqfifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(reqfifo_wvalid),
    .wready_o(reqfifo_wready),
    .wdata_i (reqfifo_wdata),
    .rvalid_o(reqfifo_rvalid),
    .rready_i(reqfifo_rready),
    .rdata_o (reqfifo_rdata)
  );

  // Lane and mask of reads in flight to the SRAM
  sync_fifo #(.WIDTH(`LANE_REC_W), .DEPTH(`OUTSTANDING), .PASS(1'b0)) u_lanefifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(lanefifo_wvalid),
    .wready_o(lanefifo_wready),
    .wdata_i (lanefifo_wdata),
    .rvalid_o(),
    .rready_i(lanefifo_rready),
    .rdata_o (lanefifo_rdata)
  );

  // Read data under D back-pressure, pass mode for zero added latency
  sync_fifo #(.WIDTH(`RSP_REC_W), .DEPTH(`OUTSTANDING), .PASS(1'b1)) u_rspfifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(rspfifo_wvalid),
    .wready_o(),
    .wdata_i (rspfifo_wdata),
    .rvalid_o(rspfifo_rvalid),
    .rready_i(rspfifo_rready),
    .rdata_o (rspfifo_rdata)
  );

endmodule

`default_nettype wire

// ==== verif/tb_monitor.sv ====
// D-channel monitor
// Compares each response in order against the queued expectations
`timescale 1ns/1ps
`default_nettype none

module tb_monitor (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               d_valid_i,
  input  logic               d_ready_i,
  input  tl_pkg::d_opcode_e  d_opcode_i,
  input  tl_pkg::tl_size_t   d_size_i,
  input  tl_pkg::tl_source_t d_source_i,
  input  tl_pkg::tl_data_t   d_data_i,
  input  logic               d_error_i,
  output int                 done_cnt_o,
  output int                 fail_cnt_o
);

  // Expected response per test, in request order
  string              name_q[$];
  logic [2:0]         opcode_q[$];
  tl_pkg::tl_size_t   size_q[$];
  tl_pkg::tl_source_t source_q[$];
  tl_pkg::tl_data_t   data_q[$];
  logic               error_q[$];

  task automatic expect_push(input string name, input logic [2:0] opcode,
                             input tl_pkg::tl_size_t size, input tl_pkg::tl_source_t source,
                             input tl_pkg::tl_data_t data, input logic error);
    name_q.push_back(name);
    opcode_q.push_back(opcode);
    size_q.push_back(size);
    source_q.push_back(source);
    data_q.push_back(data);
    error_q.push_back(error);
  endtask

  // Prints a Fail line for one field and returns whether it differed
  function automatic bit field_differs(input string name, input string field,
                                       input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s: %s expected %h actual %h", name, field, exp, act);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  initial begin
    done_cnt_o = 0;
    fail_cnt_o = 0;
  end

  // A response is taken on a valid/ready edge
  always @(posedge clk_i) begin
    string name;
    bit    bad;
    if (rst_ni && d_valid_i && d_ready_i) begin
      if (name_q.size() == 0) begin
        $display("Unexpected D response with no request outstanding");
        fail_cnt_o <= fail_cnt_o + 1;
      end else begin
        name = name_q.pop_front();
        bad  = 1'b0;
        bad |= field_differs(name, "data", data_q.pop_front(), d_data_i);
        bad |= field_differs(name, "error", 32'(error_q.pop_front()), 32'(d_error_i));
        bad |= field_differs(name, "opcode", 32'(opcode_q.pop_front()), 32'(d_opcode_i));
        bad |= field_differs(name, "size", 32'(size_q.pop_front()), 32'(d_size_i));
        bad |= field_differs(name, "source", 32'(source_q.pop_front()), 32'(d_source_i));
        if (bad) begin
          fail_cnt_o <= fail_cnt_o + 1;
        end else begin
          $display("ok   %s", name);
        end
        done_cnt_o <= done_cnt_o + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/sram_adapter_chk.sv ====
// Protocol assertions for the SRAM adapter
// Read returns, D-channel hold and error gating of the SRAM request
`timescale 1ns/1ps
`default_nettype none

module sram_adapter_chk (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        a_valid_i,
  input logic        a_ready_o,
  input logic [2:0]  a_opcode_i,
  input logic [1:0]  a_size_i,
  input logic [3:0]  a_mask_i,
  input logic [31:0] a_address_i,
  input logic        req_o,
  input logic        rvalid_i,
  input logic        d_valid_o,
  input logic        d_ready_i,
  input logic [2:0]  d_opcode_o,
  input logic [1:0]  d_size_o,
  input logic [7:0]  d_source_o,
  input logic [31:0] d_data_o,
  input logic        d_error_o
);

  // Legal Gets accepted but not yet answered by the SRAM
  logic [2:0] pending_q;
  // Request that breaks the bus rules for opcode, size, alignment or mask
  logic       bad_req;
  // Byte lanes that size and address select
  logic [3:0] sel_lanes;
  int         n_bytes;
  // Count of failed assertions
  int         fail_cnt = 0;

  always_comb begin
    n_bytes   = 1 << a_size_i;
    sel_lanes = 4'(((1 << n_bytes) - 1) << a_address_i[1:0]);
    bad_req   = !(a_opcode_i inside {3'h0, 3'h1, 3'h4}) || (a_size_i > 2'd2) ||
                ((a_address_i[1:0] & 2'(n_bytes - 1)) != 2'b00) ||
                ((a_mask_i & ~sel_lanes) != 4'h0) ||
                ((a_opcode_i == 3'h0) && (a_mask_i != sel_lanes));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_q
                   + 3'(a_valid_i & a_ready_o & (a_opcode_i == 3'h4) & ~bad_req)
                   - 3'(rvalid_i);
    end
  end

  a_rvalid_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> pending_q != 0)
    else begin
      $error("rvalid without a pending read");
      fail_cnt++;
    end

  a_d_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o && !d_ready_i |=> d_valid_o &&
      $stable({d_opcode_o, d_size_o, d_source_o, d_data_o, d_error_o}))
    else begin
      $error("D response changed before it was taken");
      fail_cnt++;
    end

  a_no_err_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_o && bad_req))
    else begin
      $error("SRAM request for an erroneous A request");
      fail_cnt++;
    end

endmodule

bind sram_adapter_top sram_adapter_chk u_chk (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .a_valid_i  (a_valid_i),
  .a_ready_o  (a_ready_o),
  .a_opcode_i (a_opcode_i),
  .a_size_i   (a_size_i),
  .a_mask_i   (a_mask_i),
  .a_address_i(a_address_i),
  .req_o      (req_o),
  .rvalid_i   (rvalid_i),
  .d_valid_o  (d_valid_o),
  .d_ready_i  (d_ready_i),
  .d_opcode_o (d_opcode_o),
  .d_size_o   (d_size_o),
  .d_source_o (d_source_o),
  .d_data_o   (d_data_o),
  .d_error_o  (d_error_o)
);

`default_nettype wire

// ==== verif/tb_top.sv ====
// SRAM adapter testbench
// Clock, reset, SRAM model, case-file driver and timeout
`timescale 1ns/1ps
`default_nettype none

`include "sram_adapter_consts.svh"

module tb_top;

  localparam int MAX_CASES    = 64;
  localparam int CYC_PER_CASE = 20;

  logic clk_i = 1'b0;
  logic rst_ni;

  logic                 a_valid_i, a_ready_o;
  tl_pkg::a_opcode_e    a_opcode_i;
  tl_pkg::tl_size_t     a_size_i;
  tl_pkg::tl_mask_t     a_mask_i;
  tl_pkg::tl_addr_t     a_address_i;
  tl_pkg::tl_data_t     a_data_i;
  tl_pkg::tl_source_t   a_source_i;
  logic                 d_valid_o, d_ready_i, d_error_o;
  tl_pkg::d_opcode_e    d_opcode_o;
  tl_pkg::tl_size_t     d_size_o;
  tl_pkg::tl_source_t   d_source_o;
  tl_pkg::tl_data_t     d_data_o;
  logic                 req_o, gnt_i, we_o, rvalid_i;
  sram_pkg::sram_addr_t addr_o;
  sram_pkg::sram_word_t wdata_o, wmask_o, rdata_i;
  logic [1:0]           rerror_i;

  // Uncorrectable flag to return for the read now on the A channel
  logic                 rerr_flag;
  sram_pkg::sram_word_t mem [1 << `SRAM_AW];

  int          n_cases, limit, cycles, done_cnt, fail_cnt;
  string       names [MAX_CASES];
  logic [31:0] ops [MAX_CASES];
  logic [31:0] addrs [MAX_CASES];
  logic [31:0] sizes [MAX_CASES];
  logic [31:0] masks [MAX_CASES];
  logic [31:0] datas [MAX_CASES];
  logic [31:0] rerrs [MAX_CASES];
  logic [31:0] exp_data [MAX_CASES];
  logic [31:0] exp_err [MAX_CASES];

  sram_adapter_top dut (.*);

  tb_monitor u_monitor (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .d_valid_i (d_valid_o),
    .d_ready_i (d_ready_i),
    .d_opcode_i(d_opcode_o),
    .d_size_i  (d_size_o),
    .d_source_i(d_source_o),
    .d_data_i  (d_data_o),
    .d_error_i (d_error_o),
    .done_cnt_o(done_cnt),
    .fail_cnt_o(fail_cnt)
  );

  always #20 clk_i = ~clk_i;

  // SRAM model with a grant about 3 of 4 cycles and read data one cycle after it
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < (1 << `SRAM_AW); i++) begin
        mem[i] <= {6'h2A, 10'(i), 16'hC0DE, 6'h15, 10'(i), 16'hBEEF};
      end
      rvalid_i <= 1'b0;
      rerror_i <= 2'b00;
    end else begin
      rvalid_i <= 1'b0;
      rerror_i <= 2'b00;
      if (req_o && gnt_i) begin
        if (we_o) begin
          mem[addr_o] <= (mem[addr_o] & ~wmask_o) | (wdata_o & wmask_o);
        end else begin
          rvalid_i <= 1'b1;
          rdata_i  <= mem[addr_o];
          rerror_i <= {rerr_flag, 1'b0};
        end
      end
    end
    gnt_i     <= ($urandom % 4) != 0;
    d_ready_i <= ($urandom % 3) != 0;
  end

  // Watchdog on the whole run
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
        $display("Run timed out before all responses arrived (%0d of %0d)",
                 done_cnt, n_cases);
        $display("Test failed");
        $finish;
      end
    end
  end

  task automatic read_cases();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("verif/sram_adapter_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file");
    end else begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h", names[n_cases],
                        ops[n_cases], addrs[n_cases], sizes[n_cases], masks[n_cases],
                        datas[n_cases], rerrs[n_cases], exp_data[n_cases],
                        exp_err[n_cases]);
          if (cnt == 9) begin
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    logic [2:0] exp_op;
    void'($urandom(32'h16000b53));
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = tl_pkg::Get;
    a_size_i    = '0;
    a_mask_i    = '0;
    a_address_i = '0;
    a_data_i    = '0;
    a_source_i  = '0;
    d_ready_i   = 1'b0;
    gnt_i       = 1'b0;
    rvalid_i    = 1'b0;
    rdata_i     = '0;
    rerror_i    = 2'b00;
    rerr_flag   = 1'b0;
    n_cases     = 0;
    limit       = 0;
    cycles      = 0;
    read_cases();
    // Puts answer with AccessAck and anything else with AccessAckData
    for (int i = 0; i < n_cases; i++) begin
      exp_op = (ops[i][2:0] inside {3'h0, 3'h1}) ? 3'h0 : 3'h1;
      u_monitor.expect_push(names[i], exp_op, sizes[i][1:0], 8'(i), exp_data[i],
                            exp_err[i][0]);
    end
    limit = n_cases * CYC_PER_CASE;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < n_cases; i++) begin
      a_valid_i   <= 1'b1;
      a_opcode_i  <= tl_pkg::a_opcode_e'(ops[i][2:0]);
      a_address_i <= addrs[i];
      a_size_i    <= sizes[i][1:0];
      a_mask_i    <= masks[i][3:0];
      a_data_i    <= datas[i];
      a_source_i  <= 8'(i);
      rerr_flag   <= rerrs[i][0];
      // Hold until the handshake edge
      do begin
        @(posedge clk_i);
      end while (!(a_valid_i && a_ready_o));
    end
    a_valid_i <= 1'b0;
    while (done_cnt < n_cases) begin
      @(posedge clk_i);
    end
    @(posedge clk_i);
    $display("%0d tests, %0d passed, %0d failed", n_cases, done_cnt - fail_cnt, fail_cnt);
    if (fail_cnt == 0 && dut.u_chk.fail_cnt == 0 && n_cases > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/sram_adapter_cases.txt ====
# name opcode address size mask data rerror | expected d_data, expected d_error
# opcode 0 PutFullData, 1 PutPartialData, 4 Get; values in hex
wr_lane0   0 00000100 2 f 11223344 0 ffffffff 0
wr_lane1   0 00000104 2 f 55667788 0 ffffffff 0
rd_lane0   4 00000100 2 f 00000000 0 11223344 0
rd_lane1   4 00000104 2 f 00000000 0 55667788 0
pp_byte0   1 00000104 0 1 000000aa 0 ffffffff 0
pp_byte3   1 00000107 0 8 bb000000 0 ffffffff 0
rd_merge   4 00000104 2 f 00000000 0 bb6677aa 0
rd_half    4 00000100 2 3 00000000 0 00003344 0
bad_align  0 00000102 2 f deadbeef 0 ffffffff 1
bad_mask   1 00000100 1 4 deadbeef 0 ffffffff 1
bad_op     2 00000100 2 f 00000000 0 ffffffff 1
bad_size   4 00000100 3 f 00000000 0 ffffffff 1
rd_after   4 00000100 2 f 00000000 0 11223344 0
rd_uerr    4 00000104 2 f 00000000 1 ffffffff 1
wr_hi_l0   0 000002f8 2 f 0badc0de 0 ffffffff 0
wr_hi_l1   0 000002fc 2 f cafef00d 0 ffffffff 0
rd_hi_l1   4 000002fc 2 f 00000000 0 cafef00d 0
rd_hi_half 4 000002fa 1 c 00000000 0 0bad0000 0
rd_hi_byte 4 000002fd 0 2 00000000 0 0000f000 0
rd_hi_l0   4 000002f8 2 f 00000000 0 0badc0de 0

// ==== files.f ====
+incdir+src
src/tl_pkg.sv
src/sram_pkg.sv
src/req_checker.sv
src/sram_lane_map.sv
src/sync_fifo.sv
src/adapter_ctrl.sv
src/sram_adapter_top.sv
verif/tb_monitor.sv
verif/sram_adapter_chk.sv
verif/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_top
FILELIST  ?= files.f
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJDIR)
